//--- logic/eth_pkg.sv
package eth_pkg;

    // Datapath widths
    localparam int BYTE_W   = 8;                        // Payload byte
    localparam int NIBBLE_W = 4;                        // PHY data lane

    // Frame layout on the wire
    localparam logic [BYTE_W-1:0] PREAMBLE_BYTE = 8'h55;   // Alternating ones and zeros
    localparam int                PREAMBLE_LEN  = 7;       // Bytes before the SFD
    localparam logic [BYTE_W-1:0] SFD_BYTE      = 8'hD5;   // Start of frame delimiter
    localparam int                FCS_LEN       = 4;       // CRC-32 trailer bytes
    localparam int                IFG_BYTES     = 12;      // Idle byte times after a frame

    // Ethernet CRC-32 in reflected form
    localparam logic [31:0] CRC_POLY_REFL = 32'hEDB8_8320;  // 0x04C11DB7 bit reversed
    localparam logic [31:0] CRC_INIT      = 32'hFFFF_FFFF;  // Preset to all ones
    localparam logic [31:0] CRC_RESIDUE   = 32'hDEBB_20E3;  // Register after data plus good FCS

    // FIFO word layouts, last flag always in bit 0
    localparam int TX_WORD_W = BYTE_W + 1;              // {data, last}
    localparam int RX_WORD_W = BYTE_W + 2;              // {data, error, last}

endpackage : eth_pkg

//--- logic/byte_stream_if.sv
`timescale 1ns/1ps

interface byte_stream_if import eth_pkg::*; ();

    logic [BYTE_W-1:0] data;                            // Byte being offered
    logic              valid;                           // Source has a byte
    logic              last;                            // Final byte of a frame
    logic              ready;                           // Sink takes the byte this edge

    modport source (
        output data,
        output valid,
        output last,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface : byte_stream_if

//--- logic/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 9,                            // Word width, last flag in bit 0
    parameter int DEPTH = 64                            // Number of words
) (
    input  logic                       i_clk,
    input  logic                       rst,
    input  logic                       wr_en,           // Ignored while full
    input  logic [WIDTH-1:0]           wr_data,
    output logic                       full,
    input  logic                       rd_en,           // Ignored while empty
    output logic [WIDTH-1:0]           rd_data,         // Head word, shown before the read
    output logic                       empty,
    output logic [$clog2(DEPTH+1)-1:0] frames_stored    // Complete frames held
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH+1);

    logic [WIDTH-1:0] mem [DEPTH];                      // Storage array
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;                            // Words held
    logic             wr_fire;
    logic             rd_fire;
    logic             wr_last;                          // Frame end entering
    logic             rd_last;                          // Frame end leaving

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign rd_data = mem[rd_ptr];                       // First word fall through

    assign wr_fire = wr_en & ~full;
    assign rd_fire = rd_en & ~empty;
    assign wr_last = wr_fire & wr_data[0];
    assign rd_last = rd_fire & rd_data[0];

    always_ff @(posedge i_clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            frames_stored <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;  // Wrap at DEPTH
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // Both or neither leaves it
            endcase
            case ({wr_last, rd_last})
                2'b10:   frames_stored <= frames_stored + 1'b1;
                2'b01:   frames_stored <= frames_stored - 1'b1;
                default: frames_stored <= frames_stored;
            endcase
        end
    end

endmodule : sync_fifo

//--- logic/crc32_unit.sv
`timescale 1ns/1ps

module crc32_unit import eth_pkg::*; (
    input  logic              i_clk,
    input  logic              rst,
    input  logic              init,                     // Preset for a new frame
    input  logic              update,                   // Fold in data this edge
    input  logic [BYTE_W-1:0] data,
    output logic [31:0]       crc                       // Running register, not inverted
);

    logic [31:0] crc_next;

    // One byte through the reflected LFSR, LSB first
    function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [BYTE_W-1:0] d);
        logic [31:0] r;
        r = c;
        for (int i = 0; i < BYTE_W; i++) begin
            if (r[0] ^ d[i]) begin
                r = (r >> 1) ^ CRC_POLY_REFL;           // Feedback tap set
            end else begin
                r = r >> 1;
            end
        end
        return r;
    endfunction

    assign crc_next = crc_byte(crc, data);

    always_ff @(posedge i_clk) begin
        if (rst) begin
            crc <= CRC_INIT;
        end else if (init) begin
            crc <= CRC_INIT;                            // Init wins over update
        end else if (update) begin
            crc <= crc_next;
        end
    end

endmodule : crc32_unit

//--- logic/mac_tx.sv
`timescale 1ns/1ps

module mac_tx import eth_pkg::*; #(
    parameter int FRAMES_W = 7                          // Width of the frame count from the FIFO
) (
    input  logic                i_clk,
    input  logic                rst,
    input  logic [FRAMES_W-1:0] frames_stored,          // Complete frames waiting
    byte_stream_if.sink         tx_bytes,
    output logic [NIBBLE_W-1:0] phy_txd,
    output logic                phy_txctl
);

    localparam logic [2:0] S_IDLE     = 3'd0;
    localparam logic [2:0] S_PREAMBLE = 3'd1;
    localparam logic [2:0] S_SFD      = 3'd2;
    localparam logic [2:0] S_PAYLOAD  = 3'd3;
    localparam logic [2:0] S_FCS      = 3'd4;
    localparam logic [2:0] S_GAP      = 3'd5;
    localparam int         BCNT_W     = $clog2(IFG_BYTES);  // Longest count is the gap

    logic [2:0]        state;
    logic              phase;                           // 0 low nibble, 1 high nibble
    logic [BCNT_W-1:0] byte_cnt;                        // Byte index inside a field
    logic              start;
    logic              pop;                             // FIFO byte consumed
    logic [31:0]       crc;
    logic [31:0]       fcs_word;
    logic [BYTE_W-1:0] cur_byte;                        // Byte on the wire now

    assign start    = (state == S_IDLE) && (frames_stored != '0);
    assign pop      = (state == S_PAYLOAD) && phase && tx_bytes.valid;
    assign fcs_word = ~crc;                             // Final inversion

    assign tx_bytes.ready = (state == S_PAYLOAD) && phase;  // Take byte with its high nibble

    always_comb begin
        case (state)
            S_PREAMBLE: cur_byte = PREAMBLE_BYTE;
            S_SFD:      cur_byte = SFD_BYTE;
            S_PAYLOAD:  cur_byte = tx_bytes.data;       // FIFO head, stable until popped
            S_FCS:      cur_byte = fcs_word[byte_cnt[1:0]*BYTE_W +: BYTE_W];  // LSB first
            default:    cur_byte = '0;
        endcase
    end

    assign phy_txd   = phase ? cur_byte[BYTE_W-1:NIBBLE_W] : cur_byte[NIBBLE_W-1:0];
    assign phy_txctl = (state == S_PREAMBLE) || (state == S_SFD) ||
                       (state == S_PAYLOAD) || (state == S_FCS);

    crc32_unit i_crc (
        .i_clk  (i_clk),
        .rst    (rst),
        .init   (start),                                // Fresh CRC per frame
        .update (pop),                                  // Payload bytes only
        .data   (tx_bytes.data),
        .crc    (crc)
    );

    always_ff @(posedge i_clk) begin
        if (rst) begin
            state    <= S_IDLE;
            phase    <= 1'b0;
            byte_cnt <= '0;
        end else if (state == S_IDLE) begin
            phase    <= 1'b0;
            byte_cnt <= '0;
            if (start) begin
                state <= S_PREAMBLE;
            end
        end else begin
            phase <= ~phase;
            if (phase) begin                            // Byte boundary
                byte_cnt <= byte_cnt + 1'b1;
                case (state)
                    S_PREAMBLE: if (byte_cnt == BCNT_W'(PREAMBLE_LEN-1)) begin
                        state    <= S_SFD;
                        byte_cnt <= '0;
                    end
                    S_SFD: begin
                        state    <= S_PAYLOAD;
                        byte_cnt <= '0;
                    end
                    S_PAYLOAD: if (pop && tx_bytes.last) begin
                        state    <= S_FCS;
                        byte_cnt <= '0;
                    end
                    S_FCS: if (byte_cnt == BCNT_W'(FCS_LEN-1)) begin
                        state    <= S_GAP;
                        byte_cnt <= '0;
                    end
                    S_GAP: if (byte_cnt == BCNT_W'(IFG_BYTES-1)) begin
                        state <= S_IDLE;
                    end
                    default: state <= S_IDLE;
                endcase
            end
        end
    end

endmodule : mac_tx

//--- logic/mac_rx.sv
`timescale 1ns/1ps

module mac_rx import eth_pkg::*; (
    input  logic                 i_clk,
    input  logic                 rst,
    input  logic [NIBBLE_W-1:0]  phy_rxd,
    input  logic                 phy_rxctl,
    output logic                 wr_en,                 // Write into rx FIFO
    output logic [RX_WORD_W-1:0] wr_data,               // {data, error, last}
    input  logic                 full,                  // rx FIFO has no room
    output logic                 rx_overflow            // Sticky, cleared by rst only
);

    logic [NIBBLE_W-1:0] rxd_q;                         // Sampled PHY nibble
    logic                rxctl_q;
    logic [NIBBLE_W-1:0] prev_nib;                      // Nibble one cycle older
    logic                prev_ctl;
    logic                in_frame;                      // Past the SFD
    logic                phase;                         // 1 when high nibble is due
    logic [NIBBLE_W-1:0] lo_nib;
    logic [BYTE_W-1:0]   dl [FCS_LEN];                  // Delay line, entry 0 newest
    logic [2:0]          dl_cnt;                        // Filled entries
    logic [BYTE_W-1:0]   head_byte;                     // Oldest byte, next to write
    logic                head_valid;
    logic                frame_err;                     // Bytes dropped in this frame
    logic                sfd_hit;
    logic                byte_done;
    logic                frame_end;
    logic                want_write;
    logic                drop;
    logic                bad_frame;
    logic [BYTE_W-1:0]   new_byte;
    logic [31:0]         crc;

    assign sfd_hit   = ~in_frame && rxctl_q && prev_ctl && ({rxd_q, prev_nib} == SFD_BYTE);
    assign byte_done = in_frame && rxctl_q && phase;
    assign frame_end = in_frame && ~rxctl_q;            // rxctl fell
    assign new_byte  = {rxd_q, lo_nib};                 // Low nibble came first

    assign want_write = (byte_done || frame_end) && head_valid;
    assign drop       = want_write && full;
    assign wr_en      = want_write && ~full;
    assign bad_frame  = (crc != CRC_RESIDUE) || frame_err || phase;  // Odd nibble count too
    assign wr_data    = {head_byte, frame_end && bad_frame, frame_end};

    crc32_unit i_crc (
        .i_clk  (i_clk),
        .rst    (rst),
        .init   (sfd_hit),
        .update (byte_done),                            // Payload and FCS alike
        .data   (new_byte),
        .crc    (crc)
    );

    always_ff @(posedge i_clk) begin
        rxd_q    <= phy_rxd;
        prev_nib <= rxd_q;
        if (in_frame && ~phase) begin
            lo_nib <= rxd_q;
        end
        if (byte_done) begin
            dl[0] <= new_byte;
            for (int i = 1; i < FCS_LEN; i++) begin
                dl[i] <= dl[i-1];
            end
            if (dl_cnt == 3'(FCS_LEN)) begin
                head_byte <= dl[FCS_LEN-1];             // Oldest leaves the delay line
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (rst) begin
            rxctl_q     <= 1'b0;
            prev_ctl    <= 1'b0;
            in_frame    <= 1'b0;
            phase       <= 1'b0;
            dl_cnt      <= '0;
            head_valid  <= 1'b0;
            frame_err   <= 1'b0;
            rx_overflow <= 1'b0;
        end else begin
            rxctl_q  <= phy_rxctl;
            prev_ctl <= rxctl_q;
            if (drop) begin
                rx_overflow <= 1'b1;
            end
            if (sfd_hit) begin
                in_frame   <= 1'b1;
                phase      <= 1'b0;
                dl_cnt     <= '0;
                head_valid <= 1'b0;
                frame_err  <= 1'b0;
            end else if (frame_end) begin
                in_frame   <= 1'b0;                     // Back to hunting
                phase      <= 1'b0;
                head_valid <= 1'b0;
            end else if (in_frame) begin
                phase <= ~phase;
                if (byte_done) begin
                    if (drop) begin
                        frame_err <= 1'b1;              // Marked on the last write
                    end
                    if (dl_cnt == 3'(FCS_LEN)) begin
                        head_valid <= 1'b1;
                    end else begin
                        dl_cnt <= dl_cnt + 1'b1;
                    end
                end
            end
        end
    end

endmodule : mac_rx

//--- logic/ethernet_mac_fifo.sv
`timescale 1ns/1ps

module ethernet_mac_fifo import eth_pkg::*; #(
    parameter int FIFO_DEPTH = 64                       // Words in each FIFO
) (
    input  logic                i_clk,
    input  logic                rst,
    input  logic [BYTE_W-1:0]   s_tx_axis_tdata,        // Bytes to send
    input  logic                s_tx_axis_tvalid,
    input  logic                s_tx_axis_tlast,
    output logic                s_tx_axis_tready,       // tx FIFO has room
    output logic [BYTE_W-1:0]   m_rx_axis_tdata,        // Received payload
    output logic                m_rx_axis_tvalid,
    output logic                m_rx_axis_tlast,
    output logic                m_rx_axis_tuser,        // Bad CRC or dropped bytes
    input  logic                m_rx_axis_tready,
    output logic [NIBBLE_W-1:0] phy_txd,
    output logic                phy_txctl,
    input  logic [NIBBLE_W-1:0] phy_rxd,
    input  logic                phy_rxctl,
    output logic                rx_overflow
);

    localparam int FRAMES_W = $clog2(FIFO_DEPTH+1);

    logic                 tx_full;
    logic                 tx_empty;
    logic [TX_WORD_W-1:0] tx_rd_data;                   // {data, last}
    logic [FRAMES_W-1:0]  tx_frames;
    logic                 rx_wr_en;
    logic [RX_WORD_W-1:0] rx_wr_data;                   // {data, error, last}
    logic                 rx_full;
    logic                 rx_empty;

    byte_stream_if tx_bytes ();                         // tx FIFO head toward the framer

    assign s_tx_axis_tready = ~tx_full;
    assign tx_bytes.valid   = ~tx_empty;
    assign {tx_bytes.data, tx_bytes.last} = tx_rd_data;
    assign m_rx_axis_tvalid = ~rx_empty;

    sync_fifo #(.WIDTH(TX_WORD_W), .DEPTH(FIFO_DEPTH)) tx_fifo (
        .i_clk (i_clk), .rst (rst),
        .wr_en (s_tx_axis_tvalid & ~tx_full), .wr_data ({s_tx_axis_tdata, s_tx_axis_tlast}),
        .full  (tx_full), .rd_en (tx_bytes.ready), .rd_data (tx_rd_data),
        .empty (tx_empty), .frames_stored (tx_frames)
    );

    mac_tx #(.FRAMES_W(FRAMES_W)) i_mac_tx (
        .i_clk (i_clk), .rst (rst), .frames_stored (tx_frames), .tx_bytes (tx_bytes),
        .phy_txd (phy_txd), .phy_txctl (phy_txctl)
    );

    mac_rx i_mac_rx (
        .i_clk (i_clk), .rst (rst), .phy_rxd (phy_rxd), .phy_rxctl (phy_rxctl),
        .wr_en (rx_wr_en), .wr_data (rx_wr_data), .full (rx_full), .rx_overflow (rx_overflow)
    );

    sync_fifo #(.WIDTH(RX_WORD_W), .DEPTH(FIFO_DEPTH)) rx_fifo (
        .i_clk (i_clk), .rst (rst), .wr_en (rx_wr_en), .wr_data (rx_wr_data),
        .full  (rx_full), .rd_en (m_rx_axis_tready),
        .rd_data ({m_rx_axis_tdata, m_rx_axis_tuser, m_rx_axis_tlast}),
        .empty (rx_empty), .frames_stored ()            // Frame count unused on rx side
    );

endmodule : ethernet_mac_fifo

//--- testbench/ethernet_mac_fifo_props.sv
`timescale 1ns/1ps

module ethernet_mac_fifo_props import eth_pkg::*; (
    input logic                 i_clk,
    input logic                 rst,
    input logic                 tx_valid,               // tx FIFO head offered to the framer
    input logic                 tx_ready,
    input logic [TX_WORD_W-1:0] tx_word,                // {data, last}
    input logic                 phy_txctl,
    input logic                 m_rx_axis_tvalid,
    input logic                 s_tx_axis_tready,
    input logic                 rx_overflow
);

    int unsigned burst_len;                             // txctl high cycles so far

    always_ff @(posedge i_clk) begin
        if (rst || !phy_txctl) begin
            burst_len <= 0;
        end else begin
            burst_len <= burst_len + 1;
        end
    end

    tx_hold: assert property (@(posedge i_clk) disable iff (rst)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_word))
        else $error("tx stream word changed while waiting for ready");

    reset_quiet: assert property (@(posedge i_clk)
        rst |=> !phy_txctl && !m_rx_axis_tvalid && s_tx_axis_tready && !rx_overflow)
        else $error("outputs not idle after reset");

    even_burst: assert property (@(posedge i_clk) disable iff (rst)
        $fell(phy_txctl) |-> burst_len[0] == 1'b0)  // Whole bytes only
        else $error("txctl burst of odd length %0d", burst_len);

endmodule : ethernet_mac_fifo_props

bind ethernet_mac_fifo ethernet_mac_fifo_props i_props (
    .i_clk            (i_clk),
    .rst              (rst),
    .tx_valid         (tx_bytes.valid),
    .tx_ready         (tx_bytes.ready),
    .tx_word          (tx_rd_data),
    .phy_txctl        (phy_txctl),
    .m_rx_axis_tvalid (m_rx_axis_tvalid),
    .s_tx_axis_tready (s_tx_axis_tready),
    .rx_overflow      (rx_overflow)
);

//--- testbench/tb_ethernet_mac_fifo.sv
`timescale 1ns/1ps

module tb_ethernet_mac_fifo;

    localparam int SEND_TIMEOUT = 2000;                 // Cycles allowed per tx byte handshake
    localparam int RX_TIMEOUT   = 40000;                // Cycles allowed for received frames
    localparam int MIN_GAP      = 2 * 12;               // 12 idle byte times in nibble cycles

    logic       i_clk;
    logic       rst;
    logic [7:0] s_tx_axis_tdata;
    logic       s_tx_axis_tvalid, s_tx_axis_tlast, s_tx_axis_tready;
    logic [7:0] m_rx_axis_tdata;
    logic       m_rx_axis_tvalid, m_rx_axis_tlast, m_rx_axis_tuser, m_rx_axis_tready;
    logic [3:0] phy_txd, phy_rxd;
    logic       phy_txctl, phy_rxctl, rx_overflow;

    string       names[$];                              // One entry per pattern line
    int          lens[$], corrupts[$], exp_errs[$], offs[$];
    logic [7:0]  pay[$];                                // All payloads end to end
    logic [3:0]  tx_nibs[$];                            // Every nibble seen with txctl high
    int          burst_lens[$];                         // txctl high cycles per frame
    logic [7:0]  rx_data[$];
    logic        rx_last[$], rx_user[$];
    int          rx_frames = 0, rx_pos = 0, tx_pos = 0;
    int          burst_nibs = 0, idle_cycles = 0, min_gap = 1000;
    int          errors = 0, test_errors = 0, passed = 0, failed = 0, n_single;
    logic [3:0]  loop_nib = '0;                         // Loopback nibble for the next cycle
    logic        loop_ctl = 1'b0, stall_mode = 1'b0;

    ethernet_mac_fifo #(.FIFO_DEPTH(64)) i_ethernet_mac_fifo (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;                      // 8 ns period
    end

    // Loopback and stream capture sampled mid cycle
    always @(negedge i_clk) begin
        if (rst) begin
            burst_nibs  = 0;
            idle_cycles = 0;
            loop_ctl    = 1'b0;
        end else if (phy_txctl) begin
            if (burst_nibs == 0 && burst_lens.size() > 0 && idle_cycles < min_gap) begin
                min_gap = idle_cycles;                  // Shortest gap between frames
            end
            loop_nib = phy_txd;
            if (burst_lens.size() < corrupts.size() && corrupts[burst_lens.size()] == burst_nibs) begin
                loop_nib = ~phy_txd;                    // Flip the selected nibble
            end
            tx_nibs.push_back(phy_txd);
            burst_nibs++;
            loop_ctl = 1'b1;
        end else begin
            if (burst_nibs != 0) begin                  // Burst just ended
                burst_lens.push_back(burst_nibs);
                burst_nibs  = 0;
                idle_cycles = 0;
            end
            idle_cycles++;
            loop_nib = '0;
            loop_ctl = 1'b0;
        end
        if (!rst && m_rx_axis_tvalid && m_rx_axis_tready) begin  // Byte leaves at next edge
            rx_data.push_back(m_rx_axis_tdata);
            rx_last.push_back(m_rx_axis_tlast);
            rx_user.push_back(m_rx_axis_tuser);
            if (m_rx_axis_tlast) begin
                rx_frames++;
            end
        end
    end

    always @(posedge i_clk) begin
        #1;
        phy_rxd          = loop_nib;
        phy_rxctl        = loop_ctl;
        m_rx_axis_tready = stall_mode ? ($urandom % 4 != 0) : 1'b1;  // Ready 3 cycles in 4
    end

    task automatic abort_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic check_value(input string test, input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            $display("FAILED %s: %s expected %0h, actual %0h", test, what, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            passed++;
            $display("test %s passed", name);
        end else begin
            failed++;
            $display("test %s failed with %0d errors", name, test_errors);
        end
    endtask

    task automatic load_patterns();
        int         fd, len, cidx, eerr;
        string      tok, line;
        logic [7:0] b;
        fd = $fopen("testbench/frame_patterns.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open testbench/frame_patterns.txt");
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                void'($fgets(line, fd));                // Rest of a comment line
            end else begin
                void'($fscanf(fd, "%d %d %d", len, cidx, eerr));
                names.push_back(tok);
                lens.push_back(len);
                corrupts.push_back(cidx);
                exp_errs.push_back(eerr);
                offs.push_back(pay.size());
                for (int k = 0; k < len; k++) begin
                    void'($fscanf(fd, "%h", b));
                    pay.push_back(b);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic send_frame(input int i);
        int waited;
        bit taken;
        for (int k = 0; k < lens[i]; k++) begin
            s_tx_axis_tdata  = pay[offs[i] + k];
            s_tx_axis_tvalid = 1'b1;
            s_tx_axis_tlast  = (k == lens[i] - 1);
            waited = 0;
            taken  = 1'b0;
            while (!taken && waited < SEND_TIMEOUT) begin
                @(negedge i_clk);
                taken = s_tx_axis_tready;               // Transfer at the coming edge
                @(posedge i_clk);
                #1;
                waited++;
            end
            if (!taken) begin
                abort_run($sformatf("Timeout while writing frame %s into the tx FIFO", names[i]));
            end
        end
        s_tx_axis_tvalid = 1'b0;
        s_tx_axis_tlast  = 1'b0;
    endtask

    task automatic wait_rx_frames(input int target);
        int waited;
        waited = 0;
        while (rx_frames < target && waited < RX_TIMEOUT) begin
            @(posedge i_clk);
            #1;
            waited++;
        end
        if (rx_frames < target) begin
            abort_run($sformatf("Timeout while waiting for received frame %0d", target));
        end
    endtask

    // Reflected CRC-32 with each byte xored into the low end
    function automatic logic [31:0] ref_crc(input int first, input int n);
        logic [31:0] c;
        c = 32'hFFFF_FFFF;
        for (int k = 0; k < n; k++) begin
            c = c ^ {24'h0, pay[first + k]};
            for (int j = 0; j < 8; j++) begin
                c = c[0] ? ((c >> 1) ^ 32'hEDB8_8320) : (c >> 1);
            end
        end
        return ~c;                                      // Final inversion
    endfunction

    task automatic check_tx(input int i);
        logic [31:0] fcs;
        logic [7:0]  b;
        logic [3:0]  nib;
        int          total, m;
        bit          ok;
        total = 2 * (8 + lens[i] + 4);                  // Preamble and SFD plus payload and FCS
        fcs   = ref_crc(offs[i], lens[i]);
        assert (burst_lens.size() > i) else begin
            $display("Test %s: no transmit burst was captured", names[i]);
            errors++;
            test_errors++;
        end
        if (burst_lens.size() > i) begin
            check_value(names[i], "txctl high cycles", total, burst_lens[i]);
            ok = (burst_lens[i] == total);
            for (int k = 0; k < total && ok; k++) begin
                m = k / 2;
                if (m < 7) begin
                    b = 8'h55;
                end else if (m == 7) begin
                    b = 8'hD5;
                end else if (m < 8 + lens[i]) begin
                    b = pay[offs[i] + m - 8];
                end else begin
                    b = fcs[8 * (m - 8 - lens[i]) +: 8];  // FCS low byte first
                end
                nib = k[0] ? b[7:4] : b[3:0];
                check_value(names[i], $sformatf("tx nibble %0d", k), nib, tx_nibs[tx_pos + k]);
                ok = (nib === tx_nibs[tx_pos + k]);     // Stop at the first mismatch
            end
            tx_pos += burst_lens[i];
        end
    endtask

    task automatic check_frame(input int i);
        int k;
        bit done;
        test_errors = 0;
        check_tx(i);
        k    = 0;
        done = 1'b0;
        while (!done && rx_pos < rx_data.size()) begin
            if (exp_errs[i] == 0 && k < lens[i]) begin  // Corrupted payloads not compared
                check_value(names[i], $sformatf("rx byte %0d", k), pay[offs[i] + k],
                            rx_data[rx_pos]);
            end
            if (rx_last[rx_pos]) begin
                check_value(names[i], "rx frame length", lens[i], k + 1);
                check_value(names[i], "tuser on last byte", exp_errs[i], rx_user[rx_pos]);
                done = 1'b1;
            end else begin
                check_value(names[i], "tuser inside frame", 0, rx_user[rx_pos]);
            end
            rx_pos++;
            k++;
        end
        finish_test(names[i]);
    endtask

    initial begin
        void'($urandom(32'hee28_7ae2));
        rst              = 1'b1;
        s_tx_axis_tdata  = '0;
        s_tx_axis_tvalid = 1'b0;
        s_tx_axis_tlast  = 1'b0;
        m_rx_axis_tready = 1'b1;
        phy_rxd          = '0;
        phy_rxctl        = 1'b0;
        load_patterns();
        n_single = names.size() / 2;                    // Second half goes back to back
        repeat (10) @(posedge i_clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < n_single; i++) begin
            send_frame(i);
            wait_rx_frames(i + 1);
            check_frame(i);
        end
        stall_mode = 1'b1;
        for (int i = n_single; i < names.size(); i++) begin
            send_frame(i);
        end
        wait_rx_frames(names.size());
        for (int i = n_single; i < names.size(); i++) begin
            check_frame(i);
        end
        test_errors = 0;
        assert (min_gap >= MIN_GAP) else begin
            $display("FAILED idle_gap: txctl low cycles expected at least %0d, actual %0d",
                     MIN_GAP, min_gap);
            errors++;
            test_errors++;
        end
        finish_test("idle_gap");
        test_errors = 0;
        check_value("rx_overflow", "rx_overflow flag", 0, rx_overflow);
        finish_test("rx_overflow");
        $display("Summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 passed + failed, passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_ethernet_mac_fifo

//--- testbench/frame_patterns.txt
# name  length  corrupt_nibble(-1 none)  expected_error  payload_bytes_hex
# First half is sent one frame at a time, second half back to back with receive stalls
single_byte 1 -1 0 a5
count_up 4 -1 0 00 01 02 03
all_ones 6 -1 0 ff ff ff ff ff ff
sfd_in_payload 8 -1 0 55 55 d5 55 d5 d5 5d 55
bad_payload 8 20 1 10 32 54 76 98 ba dc fe
bad_fcs 8 35 1 de ad be ef 01 23 45 67
burst_a 16 -1 0 00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff
burst_b 12 -1 0 0f 1e 2d 3c 4b 5a 69 78 87 96 a5 b4
burst_bad 10 23 1 c0 ff ee 00 ba be 12 34 56 78
burst_c 20 -1 0 01 02 04 08 10 20 40 80 fe fd fb f7 ef df bf 7f 3a 5c 9e e1
burst_d 2 -1 0 c3 3c
burst_e 14 -1 0 a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac ad

//--- files.f
logic/eth_pkg.sv
logic/byte_stream_if.sv
logic/sync_fifo.sv
logic/crc32_unit.sv
logic/mac_tx.sv
logic/mac_rx.sv
logic/ethernet_mac_fifo.sv
testbench/ethernet_mac_fifo_props.sv
testbench/tb_ethernet_mac_fifo.sv

//--- Bender.yml
package:
  name: ethernet_mac_fifo

sources:
  - files:
      - logic/eth_pkg.sv
      - logic/byte_stream_if.sv
      - logic/sync_fifo.sv
      - logic/crc32_unit.sv
      - logic/mac_tx.sv
      - logic/mac_rx.sv
      - logic/ethernet_mac_fifo.sv
  - target: test
    files:
      - testbench/ethernet_mac_fifo_props.sv
      - testbench/tb_ethernet_mac_fifo.sv
